// File: bench/fe_frontend_checker.sv
// Checker with concurrent assertions on the front end top level
`timescale 1ns/1ns
`include "fe_params.svh"

module fe_frontend_checker (
    input logic                     clk_sys,
    input logic                     rst_n,
    input logic                     mouse_st,
    input logic                     crop_ok,
    input fe_video_pkg::crop_size_t crop_size,
    input logic                     db15_en,
    input logic                     uart_en,
    input logic [6:0]               user_out
);

    int fail_count = 0;

    a_mouse_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
        mouse_st |=> !mouse_st)
        else begin
            $error("mouse_st stayed high for two cycles");
            fail_count = fail_count + 1;
        end

    // A nonzero crop size needs the crop permission one cycle earlier
    a_crop_size: assert property (@(posedge clk_sys) disable iff (!rst_n)
        crop_size == 12'd0 || (crop_size == 12'(`FE_CROP_LINES) && $past(crop_ok)))
        else begin
            $error("crop_size is not zero and not the crop line count after a permitted crop");
            fail_count = fail_count + 1;
        end

    // Mode bits low now and one cycle back, so the idle level is registered
    a_idle_port: assert property (@(posedge clk_sys) disable iff (!rst_n)
        (!db15_en && !uart_en && !$past(db15_en) && !$past(uart_en)) |->
        user_out == `FE_PORT_IDLE)
        else begin
            $error("user_out not idle with both port modes off");
            fail_count = fail_count + 1;
        end

endmodule

bind fe_frontend_top fe_frontend_checker u_frontend_checker (.*);

// File: bench/fe_monitor.sv
// Monitor that models the front end rules and compares the DUT outputs
`timescale 1ns/1ns
`include "fe_params.svh"

module fe_monitor (
    input  logic                     clk_sys,
    input  logic                     rst_n,
    input  logic [63:0]              status,
    input  logic [11:0]              hdmi_width, hdmi_height,
    input  logic                     force_scan2x, direct_video, rotate0, core_vertical,
    input  logic                     crop_ok,
    input  fe_video_pkg::crop_off_t  crop_off,
    input  fe_video_pkg::crop_size_t crop_size,
    input  logic [15:0]              menu_mask,
    input  logic [6:0]               user_in, joy_out, user_out,
    input  logic                     game_tx, uart_tx, uart_rx,
    input  logic                     db15_en, uart_en,
    input  logic [24:0]              ps2_mouse,
    input  logic                     mouse_st,
    input  logic [7:0]               mouse_f,
    input  fe_io_pkg::mouse_delta_t  mouse_dx, mouse_dy,
    input  logic                     check_reset, check_vector, report_req,
    input  int                       assert_fails,
    output int                       total_errors
);

    int   reset_errors = 0;
    int   crop_errors  = 0;
    int   menu_errors  = 0;
    int   port_errors  = 0;
    int   mouse_errors = 0;
    logic prev_toggle;

    assign total_errors = reset_errors + crop_errors + menu_errors + port_errors +
                          mouse_errors + assert_fails;

    function automatic int report_mismatch(input string name, input logic [31:0] expected,
                                           input logic [31:0] actual);
        if (expected === actual) begin
            return 0;
        end
        $display("CHECK FAILED %s: expected %0h, actual %0h at %0t",
                 name, expected, actual, $time);
        return 1;
    endfunction

    // Crop, menu and user port rules on inputs held long enough to settle
    task automatic check_held_vector();
        fe_video_pkg::crop_scale_e scale;
        fe_io_pkg::user_port_u     exp_port;
        logic                      exp_ok;
        logic [3:0]                opt;
        int                        exp_off;
        logic [15:0]               exp_mask;
        scale  = fe_video_pkg::crop_scale_e'({1'b0, status[`FE_ST_SCALE_LO +: 2]});
        exp_ok = hdmi_width == 12'(`FE_HDMI_CROP_W) && hdmi_height == 12'(`FE_HDMI_CROP_H) &&
                 status[`FE_ST_SCANFX_HI:`FE_ST_SCANFX_LO] == 3'd0 && !force_scan2x &&
                 scale == fe_video_pkg::normal && !direct_video && !rotate0;
        opt     = status[`FE_ST_VCOPT_LO +: 4];
        exp_off = 2 * int'(opt);
        if (opt >= 4'(`FE_CROP_WRAP_OPT)) begin
            exp_off = exp_off - `FE_CROP_WRAP_SUB;
        end
        crop_errors += report_mismatch("crop_ok", 32'(exp_ok), 32'(crop_ok));
        crop_errors += report_mismatch("crop_size", (exp_ok && status[`FE_ST_CROP_EN]) ?
                                       32'(`FE_CROP_LINES) : 32'd0, 32'(crop_size));
        crop_errors += report_mismatch("crop_off", 32'(exp_off), 32'(crop_off));
        exp_mask    = 16'h0018;
        exp_mask[5] = exp_ok;
        exp_mask[2] = !status[`FE_ST_HSIZE_EN];
        exp_mask[1] = !core_vertical;
        exp_mask[0] = direct_video;
        menu_errors += report_mismatch("menu_mask", 32'(exp_mask), 32'(menu_mask));
        port_errors += report_mismatch("db15_en", 32'(status[`FE_ST_DB15]), 32'(db15_en));
        port_errors += report_mismatch("uart_en", 32'(status[`FE_ST_UART]), 32'(uart_en));
        exp_port.pins = `FE_PORT_IDLE;
        if (status[`FE_ST_DB15]) begin
            exp_port.pins = joy_out;
        end else if (status[`FE_ST_UART]) begin
            exp_port.uart.high = 6'h3f;
            exp_port.uart.tx   = game_tx & uart_tx;
        end
        port_errors += report_mismatch("user_out", 32'(exp_port.pins), 32'(user_out));
        port_errors += report_mismatch("uart_rx",
                                       status[`FE_ST_UART] ? 32'(user_in[1]) : 32'd1,
                                       32'(uart_rx));
    endtask

    task automatic check_mouse();
        fe_io_pkg::mouse_delta_t exp_dx;
        fe_io_pkg::mouse_delta_t exp_dy;
        exp_dx = {ps2_mouse[`FE_MS_DX_SIGN], ps2_mouse[15:8]};
        exp_dy = {ps2_mouse[`FE_MS_DY_SIGN], ps2_mouse[23:16]};
        mouse_errors += report_mismatch("mouse_st",
                                        32'(ps2_mouse[`FE_MS_TOGGLE] ^ prev_toggle),
                                        32'(mouse_st));
        mouse_errors += report_mismatch("mouse_f", 32'(ps2_mouse[7:0]), 32'(mouse_f));
        mouse_errors += report_mismatch("mouse_dx", 32'(exp_dx), 32'(mouse_dx));
        mouse_errors += report_mismatch("mouse_dy", 32'(exp_dy), 32'(mouse_dy));
    endtask

    always @(posedge clk_sys) begin
        if (check_reset) begin
            reset_errors += report_mismatch("reset user_out", 32'(`FE_PORT_IDLE),
                                            32'(user_out));
            reset_errors += report_mismatch("reset crop_ok", 32'd0, 32'(crop_ok));
            reset_errors += report_mismatch("reset crop_size", 32'd0, 32'(crop_size));
            reset_errors += report_mismatch("reset db15_en", 32'd0, 32'(db15_en));
            reset_errors += report_mismatch("reset uart_en", 32'd0, 32'(uart_en));
            reset_errors += report_mismatch("reset mouse_st", 32'd0, 32'(mouse_st));
        end
        if (check_vector) begin
            check_held_vector();
        end
        if (rst_n) begin
            check_mouse();
        end
        // Copy of the toggle bit as the DUT registers it
        prev_toggle <= rst_n ? ps2_mouse[`FE_MS_TOGGLE] : 1'b0;
        if (report_req) begin
            $display("Errors: reset %0d, crop %0d, menu %0d, port %0d, mouse %0d, assert %0d",
                     reset_errors, crop_errors, menu_errors, port_errors, mouse_errors,
                     assert_fails);
        end
    end

endmodule

// File: bench/fe_tb.sv
// Testbench for the front end with clock, reset, random stimulus and run control
`timescale 1ns/1ns
`include "fe_params.svh"

module fe_tb;

    localparam int RESET_CYCLES   = 10;
    localparam int VECTOR_COUNT   = 200;
    localparam int HOLD_CYCLES    = 8;
    localparam int MOUSE_CYCLES   = 150;
    // Stimulus needs about 1970 cycles
    localparam int TIMEOUT_CYCLES = 3000;

    logic                     clk_sys = 1'b0;
    logic                     rst_n;
    logic [63:0]              status;
    logic [11:0]              hdmi_width, hdmi_height;
    logic                     force_scan2x, direct_video, rotate0, core_vertical;
    logic                     crop_ok;
    fe_video_pkg::crop_off_t  crop_off;
    fe_video_pkg::crop_size_t crop_size;
    logic [15:0]              menu_mask;
    logic [6:0]               user_in, joy_out, user_out;
    logic                     game_tx, uart_tx, uart_rx, db15_en, uart_en;
    logic [24:0]              ps2_mouse;
    logic                     mouse_st;
    logic [7:0]               mouse_f;
    fe_io_pkg::mouse_delta_t  mouse_dx, mouse_dy;
    logic                     check_reset, check_vector, report_req;
    int                       total_errors;
    int                       cycle_count = 0;
    logic [31:0]              rng_state = 32'haec1;

    always #4 clk_sys = ~clk_sys;

    fe_frontend_top u_fe_frontend_top (.*);

    fe_monitor u_monitor (
        .assert_fails ( u_fe_frontend_top.u_frontend_checker.fail_count ),
        .*
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw_random(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value     = rng_state;
    endtask

    // Biased so that crop permission comes up now and then
    task automatic drive_vector(input int index);
        logic [31:0] r0, r1, r2, r3;
        draw_random(r0);
        draw_random(r1);
        draw_random(r2);
        draw_random(r3);
        status = {r0, r1};
        // First 16 vectors walk every crop option
        if (index < 16) begin
            status[`FE_ST_VCOPT_LO +: 4] = 4'(index);
        end
        if (r2[2]) begin
            status[`FE_ST_SCANFX_HI:`FE_ST_SCANFX_LO] = 3'd0;
        end
        if (r2[3]) begin
            status[`FE_ST_SCALE_LO +: 2] = 2'd0;
        end
        if (r2[1:0] == 2'd0) begin
            hdmi_width  = 12'(`FE_HDMI_CROP_W);
            hdmi_height = 12'(`FE_HDMI_CROP_H);
        end else begin
            hdmi_width  = r3[11:0];
            hdmi_height = r3[23:12];
        end
        force_scan2x  = (r2[5:4] == 2'd0);
        direct_video  = (r2[7:6] == 2'd0);
        rotate0       = (r2[9:8] == 2'd0);
        core_vertical = r2[10];
        joy_out       = r2[17:11];
        game_tx       = r2[18];
        uart_tx       = r2[19];
        user_in       = r2[26:20];
    endtask

    initial begin
        logic [31:0] r;
        logic        flip;
        logic        flipped;
        rst_n         = 1'b0;
        // Both port modes on and a permitted crop while reset is held
        status        = '0;
        status[`FE_ST_DB15]    = 1'b1;
        status[`FE_ST_UART]    = 1'b1;
        status[`FE_ST_CROP_EN] = 1'b1;
        hdmi_width    = 12'(`FE_HDMI_CROP_W);
        hdmi_height   = 12'(`FE_HDMI_CROP_H);
        force_scan2x  = 1'b0;
        direct_video  = 1'b0;
        rotate0       = 1'b0;
        core_vertical = 1'b0;
        user_in       = '0;
        joy_out       = 7'h2a;
        game_tx       = 1'b0;
        uart_tx       = 1'b0;
        ps2_mouse     = '0;
        check_reset   = 1'b0;
        check_vector  = 1'b0;
        report_req    = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_sys);
        rst_n       = 1'b1;
        check_reset = 1'b1;
        @(negedge clk_sys);
        check_reset = 1'b0;
        for (int i = 0; i < VECTOR_COUNT; i++) begin
            drive_vector(i);
            repeat (HOLD_CYCLES) @(negedge clk_sys);
            check_vector = 1'b1;
            @(negedge clk_sys);
            check_vector = 1'b0;
        end
        flipped = 1'b0;
        for (int i = 0; i < MOUSE_CYCLES; i++) begin
            draw_random(r);
            // Toggle bit never moves on two cycles in a row
            flip      = r[24] & ~flipped;
            ps2_mouse = {ps2_mouse[24] ^ flip, r[23:0]};
            flipped   = flip;
            @(negedge clk_sys);
        end
        report_req = 1'b1;
        @(negedge clk_sys);
        report_req = 1'b0;
        if (total_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles without reaching the end of the run",
                     TIMEOUT_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

endmodule

// File: list.f
+incdir+verilog
verilog/fe_io_pkg.sv
verilog/fe_video_pkg.sv
verilog/fe_status_if.sv
verilog/fe_status_decode.sv
verilog/fe_video_ctrl.sv
verilog/fe_user_port.sv
verilog/fe_mouse_decode.sv
verilog/fe_frontend_top.sv
bench/fe_frontend_checker.sv
bench/fe_monitor.sv
bench/fe_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module fe_tb -Mdir "$BUILD_DIR" -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"$BUILD_DIR/Vfe_tb" +verilator+error+limit+100 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
exit 0

// File: verilog/fe_frontend_top.sv
// Front end top: status decode, crop and menu control, user port and mouse decode
`timescale 1ns/1ns

module fe_frontend_top (
    input  logic                     clk_sys,
    input  logic                     rst_n,
    input  logic [63:0]              status,
    // HDMI and video options
    input  logic [11:0]              hdmi_width,
    input  logic [11:0]              hdmi_height,
    input  logic                     force_scan2x,
    input  logic                     direct_video,
    input  logic                     rotate0,
    input  logic                     core_vertical,
    output logic                     crop_ok,
    output fe_video_pkg::crop_off_t  crop_off,
    output fe_video_pkg::crop_size_t crop_size,
    output logic [15:0]              menu_mask,
    // User port
    input  logic [6:0]               user_in,
    input  logic [6:0]               joy_out,
    input  logic                     game_tx,
    input  logic                     uart_tx,
    output logic [6:0]               user_out,
    output logic                     uart_rx,
    output logic                     db15_en,
    output logic                     uart_en,
    // PS/2 mouse
    input  logic [24:0]              ps2_mouse,
    output logic                     mouse_st,
    output logic [7:0]               mouse_f,
    output fe_io_pkg::mouse_delta_t  mouse_dx,
    output fe_io_pkg::mouse_delta_t  mouse_dy
);

    fe_status_if st_if ();

    fe_status_decode u_status_decode (
        .clk_sys       ( clk_sys       ),
        .rst_n         ( rst_n         ),
        .status        ( status        ),
        .st            ( st_if.decode  )
    );

    fe_video_ctrl u_video_ctrl (
        .clk_sys       ( clk_sys       ),
        .rst_n         ( rst_n         ),
        .st            ( st_if.video   ),
        .hdmi_width    ( hdmi_width    ),
        .hdmi_height   ( hdmi_height   ),
        .force_scan2x  ( force_scan2x  ),
        .direct_video  ( direct_video  ),
        .rotate0       ( rotate0       ),
        .core_vertical ( core_vertical ),
        .crop_ok       ( crop_ok       ),
        .crop_off      ( crop_off      ),
        .crop_size     ( crop_size     ),
        .menu_mask     ( menu_mask     )
    );

    fe_user_port u_user_port (
        .clk_sys       ( clk_sys       ),
        .rst_n         ( rst_n         ),
        .st            ( st_if.port    ),
        .user_in       ( user_in       ),
        .joy_out       ( joy_out       ),
        .game_tx       ( game_tx       ),
        .uart_tx       ( uart_tx       ),
        .user_out      ( user_out      ),
        .uart_rx       ( uart_rx       )
    );

    fe_mouse_decode u_mouse_decode (
        .clk_sys       ( clk_sys       ),
        .rst_n         ( rst_n         ),
        .ps2_mouse     ( ps2_mouse     ),
        .mouse_st      ( mouse_st      ),
        .mouse_f       ( mouse_f       ),
        .mouse_dx      ( mouse_dx      ),
        .mouse_dy      ( mouse_dy      )
    );

    // Mode state made visible outside
    assign db15_en = st_if.db15_en;
    assign uart_en = st_if.uart_en;

endmodule

// File: verilog/fe_io_pkg.sv
// I/O types for the user port and the PS/2 mouse
package fe_io_pkg;

    // UART use of the port, transmit line at bit 0
    typedef struct packed {
        logic [5:0] high;
        logic       tx;
    } uart_view_t;

    // Same 7 pins read as DB15 joystick lines or as the UART view
    typedef union packed {
        logic [6:0] pins;
        uart_view_t uart;
    } user_port_u;

    // Mouse movement with the sign taken from the flag byte
    typedef logic signed [8:0] mouse_delta_t;

endpackage

// File: verilog/fe_mouse_decode.sv
// Mouse decoder: splits the PS/2 packet and strobes on each new packet
`timescale 1ns/1ns
`include "fe_params.svh"

module fe_mouse_decode (
    input  logic                    clk_sys,
    input  logic                    rst_n,
    input  logic [24:0]             ps2_mouse,
    output logic                    mouse_st,
    output logic [7:0]              mouse_f,
    output fe_io_pkg::mouse_delta_t mouse_dx,
    output fe_io_pkg::mouse_delta_t mouse_dy
);

    logic toggle_l;

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            toggle_l <= 1'b0;
        end else begin
            toggle_l <= ps2_mouse[`FE_MS_TOGGLE];
        end
    end

    // New packet whenever the toggle bit moves
    assign mouse_st = ps2_mouse[`FE_MS_TOGGLE] ^ toggle_l;
    assign mouse_f  = ps2_mouse[7:0];

    // Sign bits live in the flag byte
    assign mouse_dx = {mouse_f[`FE_MS_DX_SIGN], ps2_mouse[15:8]};
    assign mouse_dy = {mouse_f[`FE_MS_DY_SIGN], ps2_mouse[23:16]};

endmodule

// File: verilog/fe_params.svh
// Front end parameters: status word bit positions, crop constants and port idle levels
`ifndef FE_PARAMS_SVH
`define FE_PARAMS_SVH

// Scan FX field in the OSD status word
`define FE_ST_SCANFX_LO   3
`define FE_ST_SCANFX_HI   5

// User port mode bits
`define FE_ST_DB15        37
`define FE_ST_UART        38

// Vertical crop and horizontal scaling fields
`define FE_ST_CROP_EN     41
`define FE_ST_VCOPT_LO    42
`define FE_ST_SCALE_LO    46
`define FE_ST_HSIZE_EN    48

// HDMI mode that tolerates vertical crop
`define FE_HDMI_CROP_W    1920
`define FE_HDMI_CROP_H    1080
`define FE_CROP_LINES     216
`define FE_CROP_WRAP_OPT  6
`define FE_CROP_WRAP_SUB  24

// Idle level of the 7-bit user port
`define FE_PORT_IDLE      7'h7f

// PS/2 mouse packet layout
`define FE_MS_TOGGLE      24
`define FE_MS_DX_SIGN     4
`define FE_MS_DY_SIGN     5

`endif

// File: verilog/fe_status_decode.sv
// Status decoder: registers the OSD fields out of the 64-bit status word
`timescale 1ns/1ns
`include "fe_params.svh"

module fe_status_decode (
    input  logic        clk_sys,
    input  logic        rst_n,
    input  logic [63:0] status,
    fe_status_if.decode st
);

    logic [2:0] scanfx;
    logic [1:0] scale_raw;

    assign scanfx    = status[`FE_ST_SCANFX_HI:`FE_ST_SCANFX_LO];
    assign scale_raw = status[`FE_ST_SCALE_LO +: 2];

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            st.crop_en      <= 1'b0;
            st.vcopt        <= 4'd0;
            st.crop_scale   <= fe_video_pkg::normal;
            st.hsize_enable <= 1'b0;
            st.scanfx_zero  <= 1'b0;
            st.db15_en      <= 1'b0;
            st.uart_en      <= 1'b0;
        end else begin
            st.crop_en      <= status[`FE_ST_CROP_EN];
            st.vcopt        <= status[`FE_ST_VCOPT_LO +: 4];
            // Only two scale bits come from the OSD, top bit stays clear
            st.crop_scale   <= fe_video_pkg::crop_scale_e'({1'b0, scale_raw});
            st.hsize_enable <= status[`FE_ST_HSIZE_EN];
            // Any scan line effect blocks cropping
            st.scanfx_zero  <= (scanfx == 3'd0);
            // Mode bits have separate positions and may both be set
            st.db15_en      <= status[`FE_ST_DB15];
            st.uart_en      <= status[`FE_ST_UART];
        end
    end

endmodule

// File: verilog/fe_status_if.sv
// Status interface: decoded OSD status fields shared by the front end blocks
`timescale 1ns/1ns

interface fe_status_if;

    logic                      crop_en;
    logic [3:0]                vcopt;
    fe_video_pkg::crop_scale_e crop_scale;
    logic                      hsize_enable;
    logic                      scanfx_zero;
    logic                      db15_en;
    logic                      uart_en;

    modport decode (
        output crop_en, vcopt, crop_scale, hsize_enable, scanfx_zero, db15_en, uart_en
    );

    // Crop and menu logic
    modport video (
        input crop_en, vcopt, crop_scale, hsize_enable, scanfx_zero
    );

    // User port mux only needs the mode bits
    modport port (
        input db15_en, uart_en
    );

endinterface

// File: verilog/fe_user_port.sv
// User port: registered DB15/UART/idle output select and UART receive line
`timescale 1ns/1ns
`include "fe_params.svh"

module fe_user_port (
    input  logic       clk_sys,
    input  logic       rst_n,
    fe_status_if.port  st,
    input  logic [6:0] user_in,
    input  logic [6:0] joy_out,
    input  logic       game_tx,
    input  logic       uart_tx,
    output logic [6:0] user_out,
    output logic       uart_rx
);

    fe_io_pkg::user_port_u port_next;

    // DB15 wins over the UART when both are enabled
    always_comb begin
        port_next.pins = `FE_PORT_IDLE;
        if (st.db15_en) begin
            port_next.pins = joy_out;
        end else if (st.uart_en) begin
            port_next.uart.high = '1;
            // Core and cheat UARTs share the one tx pin
            port_next.uart.tx   = game_tx & uart_tx;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            user_out <= `FE_PORT_IDLE;
        end else begin
            user_out <= port_next.pins;
        end
    end

    // Line idles high when the UART is off
    assign uart_rx = st.uart_en ? user_in[1] : 1'b1;

endmodule

// File: verilog/fe_video_ctrl.sv
// Video control: vertical crop permission, offset and size plus the OSD menu mask
`timescale 1ns/1ns
`include "fe_params.svh"

module fe_video_ctrl (
    input  logic                     clk_sys,
    input  logic                     rst_n,
    fe_status_if.video               st,
    input  logic [11:0]              hdmi_width,
    input  logic [11:0]              hdmi_height,
    input  logic                     force_scan2x,
    input  logic                     direct_video,
    input  logic                     rotate0,
    input  logic                     core_vertical,
    output logic                     crop_ok,
    output fe_video_pkg::crop_off_t  crop_off,
    output fe_video_pkg::crop_size_t crop_size,
    output logic [15:0]              menu_mask
);

    logic       hdmi_1080p;
    logic       crop_allowed;
    logic [4:0] off_x2;
    logic [4:0] off_next;

    assign hdmi_1080p = (hdmi_width == 12'(`FE_HDMI_CROP_W)) &&
                        (hdmi_height == 12'(`FE_HDMI_CROP_H));

    // The scaler only copes with cropping in plain 1080p output
    assign crop_allowed = hdmi_1080p && st.scanfx_zero && !force_scan2x &&
                          (st.crop_scale == fe_video_pkg::normal) &&
                          !direct_video && !rotate0;

    // Two lines per option step, upper options wrap to negative offsets
    assign off_x2   = {st.vcopt, 1'b0};
    assign off_next = (st.vcopt < 4'(`FE_CROP_WRAP_OPT)) ?
                      off_x2 : off_x2 - 5'(`FE_CROP_WRAP_SUB);

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            crop_ok   <= 1'b0;
            crop_size <= '0;
        end else begin
            crop_ok   <= crop_allowed;
            // Uses last cycle's permission, one cycle behind crop_ok
            crop_size <= (crop_ok && st.crop_en) ?
                         fe_video_pkg::crop_size_t'(`FE_CROP_LINES) : '0;
        end
    end

    always_ff @(posedge clk_sys) begin
        crop_off <= fe_video_pkg::crop_off_t'(off_next);
    end

    // A set bit hides the matching OSD entry
    // No rotate menu and no 60 Hz option in this build, so bits 4 and 3 stay hidden
    assign menu_mask = {
        10'd0,
        crop_ok,
        1'b1,
        1'b1,
        ~st.hsize_enable,
        ~core_vertical,
        direct_video
    };

endmodule

// File: verilog/fe_video_pkg.sv
// Video types for the HDMI vertical crop settings
package fe_video_pkg;

    // Scaler modes selected from the OSD
    typedef enum logic [2:0] {
        normal           = 3'd0,
        v_integer        = 3'd1,
        hv_integer_minus = 3'd2,
        hv_integer_plus  = 3'd3,
        hv_integer       = 3'd4
    } crop_scale_e;

    // Offset range is -16 to +15 lines
    typedef logic signed [4:0] crop_off_t;

    // Number of lines cropped
    typedef logic [11:0] crop_size_t;

endpackage
